// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := alu_core_tb
FILELIST  := alu_core.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Simulation completed successfully

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== alu_core.f ====
verilog/alu_pkg.sv
verilog/apb_pkg.sv
verilog/alu_ifs.sv
verilog/apb_regs.sv
verilog/alu_decode.sv
verilog/alu_execute.sv
verilog/alu_result.sv
verilog/alu_core.sv
tests/tb_clock.sv
tests/alu_core_checker.sv
tests/alu_core_tb.sv

// ==== tests/alu_core_checker.sv ====
// Assertions on the APB response of the ALU
// Error response timing, idle ready level and the busy window after a launch
// Bound into alu_core
module alu_core_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic launch_i,
    input logic busy_i
);
    int unsigned fail_cnt = 0;

    // Error response only in the cycle that completes an access
    slverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> psel_i && penable_i && pready_i)
        else begin
            $error("pslverr high outside a completing access cycle");
            fail_cnt++;
        end

    // Write-back ends busy one cycle after it was set
    busy_falls: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(launch_i, 2) && !$past(launch_i) |-> !busy_i)
        else begin
            $error("busy still set one cycle after the launch cycle");
            fail_cnt++;
        end

    ready_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !psel_i |-> pready_i)
        else begin
            $error("pready low while the slave is not selected");
            fail_cnt++;
        end
endmodule

bind alu_core alu_core_checker checker_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .launch_i  (launch),
    .busy_i    (apb_regs_i.busy_q)
);

// ==== tests/alu_core_tb.sv ====
// Testbench for the APB-attached ALU
// APB transfer tasks, reference model and compare process
// Directed and random tests, watchdog and closing summary
module alu_core_tb;
    import alu_pkg::*;
    import apb_pkg::*;

    localparam int  N_ITER       = 8;
    localparam int  N_MOVE       = 4;
    localparam int  RESET_CYCLES = 10;
    localparam int  CLK_PERIOD   = 20;
    // Seven transfers per operation, plus the reset reads and the bad accesses
    localparam int  N_XFER  = 7 + 7 * (19 * N_ITER + 4 * N_MOVE + 8 + 10) + 6;
    localparam longint TIMEOUT = longint'(N_XFER) * 8 * CLK_PERIOD
                                 + RESET_CYCLES * CLK_PERIOD;

    typedef struct packed {
        word_t res;
        word_t hi;
        word_t lo;
        logic  ovf;
        logic  ill;
    } model_t;

    logic      clk;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    model_t    m;
    int        n_checks;
    int        n_errors;
    int        errs_before;
    string     lbl_q[$];
    word_t     got_q[$];
    word_t     exp_q[$];
    event      got_ev;

    tb_clock clock_i (.clk_o(clk));

    alu_core alu_core_i (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    // Expected state after one operation on the given HI, LO and RESULT
    function automatic model_t alu_model(input logic [4:0] code, input word_t a,
                                         input word_t b, input word_t hi,
                                         input word_t lo, input word_t res);
        model_t r;
        dword_t p;
        longint s;
        int     n;
        r.res = res;
        r.hi  = hi;
        r.lo  = lo;
        r.ovf = 1'b0;
        r.ill = 1'b0;
        n     = 0;
        case (code)
            OP_OR:   r.res = a | b;
            OP_AND:  r.res = a & b;
            OP_NOR:  r.res = ~(a | b);
            OP_XOR:  r.res = a ^ b;
            OP_SLL:  r.res = b << a[4:0];
            OP_SRL:  r.res = b >> a[4:0];
            OP_SRA:  r.res = word_t'($signed(b) >>> a[4:0]);
            OP_ADD, OP_SUB: begin
                if (code == OP_ADD) begin
                    s = longint'($signed(a)) + longint'($signed(b));
                end else begin
                    s = longint'($signed(a)) - longint'($signed(b));
                end
                // Overflow when the exact value does not fit in 32 signed bits
                if (s != longint'($signed(word_t'(s)))) begin
                    r.ovf = 1'b1;
                end else begin
                    r.res = word_t'(s);
                end
            end
            OP_ADDU: r.res = a + b;
            OP_SUBU: r.res = a - b;
            OP_SLT:  r.res = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU: r.res = {31'b0, a < b};
            OP_CLZ, OP_CLO: begin
                while (n < 32 && a[31 - n] == (code == OP_CLO)) begin
                    n++;
                end
                r.res = word_t'(n);
            end
            OP_MUL, OP_MULT: begin
                p = dword_t'(longint'($signed(a)) * longint'($signed(b)));
                if (code == OP_MUL) begin
                    r.res = p[31:0];
                end else begin
                    {r.hi, r.lo} = p;
                end
            end
            OP_MULTU: {r.hi, r.lo} = {32'b0, a} * {32'b0, b};
            OP_MFHI: r.res = hi;
            OP_MFLO: r.res = lo;
            OP_MTHI: r.hi = a;
            OP_MTLO: r.lo = a;
            default: r.ill = 1'b1;
        endcase
        return r;
    endfunction

    task automatic check_eq(input string label, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error @%0t: %s read %08h, expected %08h", $time, label, got, exp);
        end
    endtask

    // Compare process, fed by the read tasks
    initial begin : compare_proc
        forever begin
            @(got_ev);
            while (got_q.size() > 0) begin
                check_eq(lbl_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            end
        end
    end

    task automatic queue_check(input string label, input word_t got, input word_t exp);
        lbl_q.push_back(label);
        got_q.push_back(got);
        exp_q.push_back(exp);
        -> got_ev;
    endtask

    // Called just after a falling edge, returns just after one with the bus idle
    task automatic bus_transfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                                output word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data);
        word_t rdata;
        logic  err;
        bus_transfer(1'b1, addr, data, rdata, err);
        queue_check($sformatf("pslverr on write %02h", addr), {31'b0, err}, 32'h0);
    endtask

    task automatic expect_reg(input apb_addr_t addr, input word_t exp, input string label);
        word_t rdata;
        logic  err;
        bus_transfer(1'b0, addr, 32'h0, rdata, err);
        queue_check({label, " pslverr"}, {31'b0, err}, 32'h0);
        queue_check(label, rdata, exp);
    endtask

    task automatic expect_error(input logic wr, input apb_addr_t addr);
        word_t rdata;
        logic  err;
        bus_transfer(wr, addr, 32'h0, rdata, err);
        queue_check($sformatf("pslverr at %02h", addr), {31'b0, err}, 32'h1);
    endtask

    // Operands, then the command, then every result register
    task automatic run_op(input logic [4:0] code, input word_t a, input word_t b);
        word_t st;
        write_reg(ADDR_OPA, a);
        write_reg(ADDR_OPB, b);
        write_reg(ADDR_CMD, {27'b0, code});
        m  = alu_model(code, a, b, m.hi, m.lo, m.res);
        st = 32'h0;
        st[STAT_OVF]     = m.ovf;
        st[STAT_ILLEGAL] = m.ill;
        expect_reg(ADDR_RESULT, m.res, $sformatf("op %0d RESULT", code));
        expect_reg(ADDR_HI, m.hi, $sformatf("op %0d HI", code));
        expect_reg(ADDR_LO, m.lo, $sformatf("op %0d LO", code));
        expect_reg(ADDR_STATUS, st, $sformatf("op %0d STATUS", code));
    endtask

    function automatic word_t pick_operand();
        case ($urandom_range(0, 5))
            0:       return 32'h0000_0000;
            1:       return 32'hFFFF_FFFF;
            2:       return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    task automatic report_test(input string name);
        @(negedge clk);
        $display("%s finished with %0d errors", name, n_errors - errs_before);
        errs_before = n_errors;
    endtask

    task automatic reset_values();
        expect_reg(ADDR_OPA, 32'h0, "reset OPA");
        expect_reg(ADDR_OPB, 32'h0, "reset OPB");
        expect_reg(ADDR_CMD, 32'h0, "reset CMD");
        expect_reg(ADDR_RESULT, 32'h0, "reset RESULT");
        expect_reg(ADDR_HI, 32'h0, "reset HI");
        expect_reg(ADDR_LO, 32'h0, "reset LO");
        expect_reg(ADDR_STATUS, 32'h0, "reset STATUS");
        report_test("reset values");
    endtask

    task automatic logic_and_arith();
        for (int c = 0; c <= 14; c++) begin
            for (int i = 0; i < N_ITER; i++) begin
                run_op(5'(c), pick_operand(), pick_operand());
            end
        end
        report_test("logic, shift and arithmetic");
    endtask

    task automatic multiply_and_moves();
        alu_op_e mul_ops[3];
        mul_ops = '{OP_MUL, OP_MULT, OP_MULTU};
        for (int j = 0; j < 3; j++) begin
            for (int i = 0; i < N_ITER; i++) begin
                run_op(mul_ops[j], pick_operand(), pick_operand());
            end
        end
        for (int i = 0; i < N_MOVE; i++) begin
            run_op(OP_MTHI, $urandom(), 32'h0);
            run_op(OP_MTLO, $urandom(), 32'h0);
            run_op(OP_MFHI, 32'h0, 32'h0);
            run_op(OP_MFLO, 32'h0, 32'h0);
        end
        report_test("multiply and HI/LO moves");
    endtask

    task automatic overflow_cases();
        word_t   ovf_a[4];
        word_t   ovf_b[4];
        alu_op_e trap_ops[4];
        alu_op_e wrap_ops[4];
        ovf_a    = '{32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'h7FFF_FFFF};
        ovf_b    = '{32'h0000_0001, 32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF};
        trap_ops = '{OP_ADD, OP_ADD, OP_SUB, OP_SUB};
        wrap_ops = '{OP_ADDU, OP_ADDU, OP_SUBU, OP_SUBU};
        for (int i = 0; i < 4; i++) begin
            run_op(trap_ops[i], ovf_a[i], ovf_b[i]);
            run_op(wrap_ops[i], ovf_a[i], ovf_b[i]);
        end
        report_test("overflow");
    endtask

    // RESULT is read in the transfer right after the CMD write
    task automatic result_after_cmd();
        for (int i = 0; i < N_ITER; i++) begin
            run_op(5'($urandom_range(0, 21)), $urandom(), $urandom());
        end
        report_test("result read after command");
    endtask

    task automatic illegal_and_bad_access();
        for (int c = 22; c <= 31; c++) begin
            run_op(5'(c), $urandom(), $urandom());
        end
        expect_error(1'b0, 8'h1C);
        expect_error(1'b0, 8'h02);
        expect_error(1'b1, 8'h20);
        expect_error(1'b1, ADDR_RESULT);
        expect_error(1'b1, ADDR_HI);
        expect_error(1'b1, ADDR_STATUS);
        report_test("illegal codes and bad accesses");
    endtask

    initial begin : watchdog
        #(TIMEOUT);
        $display("The run timed out after %0d time units with tests still running", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(76010));
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        m           = '0;
        n_checks    = 0;
        n_errors    = 0;
        errs_before = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_values();
        logic_and_arith();
        multiply_and_moves();
        overflow_cases();
        result_after_cmd();
        illegal_and_bad_access();

        $display("Totals: %0d checks, %0d errors, %0d assertion failures",
                 n_checks, n_errors, alu_core_i.checker_i.fail_cnt);
        if (n_errors == 0 && alu_core_i.checker_i.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// ==== tests/tb_clock.sv ====
// Free-running testbench clock
// Period of 20 time units, starting low
module tb_clock (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #10;
        clk_o = ~clk_o;
    end
endmodule

// ==== verilog/alu_core.sv ====
// ALU top level with plain APB ports
// Connects the APB slave, decode, execute and write-back stages
module alu_core (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  apb_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  alu_pkg::word_t     pwdata_i,
    output alu_pkg::word_t     prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);
    import alu_pkg::*;

    logic    launch;
    alu_op_e op;
    word_t   opa;
    word_t   opb;
    logic    done;
    word_t   result;
    word_t   hi;
    word_t   lo;
    logic    ovf;
    logic    illegal;

    dec_if  dec_bus ();
    unit_if unit_bus ();

    apb_regs apb_regs_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .paddr_i   (paddr_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .launch_o  (launch),
        .op_o      (op),
        .opa_o     (opa),
        .opb_o     (opb),
        .done_i    (done),
        .result_i  (result),
        .hi_i      (hi),
        .lo_i      (lo),
        .ovf_i     (ovf),
        .illegal_i (illegal)
    );

    alu_decode alu_decode_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .launch_i (launch),
        .op_i     (op),
        .opa_i    (opa),
        .opb_i    (opb),
        .dec      (dec_bus.dec)
    );

    alu_execute alu_execute_i (
        .hi_i  (hi),
        .lo_i  (lo),
        .dec   (dec_bus.exe),
        .units (unit_bus.exe)
    );

    alu_result alu_result_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dec       (dec_bus.res),
        .units     (unit_bus.res),
        .done_o    (done),
        .result_o  (result),
        .hi_o      (hi),
        .lo_o      (lo),
        .ovf_o     (ovf),
        .illegal_o (illegal)
    );

endmodule

// ==== verilog/alu_decode.sv ====
// ALU decode stage
// Registers a launched command with its operands
// Derives class, subtract, signed-multiply, overflow-check and illegal fields
module alu_decode (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             launch_i,
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::word_t   opa_i,
    input  alu_pkg::word_t   opb_i,
    dec_if.dec               dec
);
    import alu_pkg::*;

    logic    valid_q;
    alu_op_e op_q;
    word_t   a_q;
    word_t   b_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            op_q    <= alu_op_e'(0);
            a_q     <= '0;
            b_q     <= '0;
        end else begin
            valid_q <= launch_i;
            if (launch_i) begin
                op_q <= op_i;
                a_q  <= opa_i;
                b_q  <= opb_i;
            end
        end
    end

    assign dec.valid = valid_q;
    assign dec.op    = op_q;
    assign dec.a     = a_q;
    assign dec.b     = b_q;

    always_comb begin
        dec.cls        = RES_LOGIC;
        dec.sub_en     = 1'b0;
        dec.mul_signed = 1'b0;
        dec.ovf_chk    = 1'b0;
        dec.illegal    = 1'b0;
        case (op_q)
            OP_OR, OP_AND, OP_NOR, OP_XOR: dec.cls = RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA: dec.cls = RES_SHIFT;
            OP_ADDU, OP_SLTU, OP_CLZ, OP_CLO: dec.cls = RES_ARITH;
            OP_MFHI, OP_MFLO: dec.cls = RES_MOVE;
            OP_MULTU, OP_MTHI, OP_MTLO: dec.cls = RES_HILO_ONLY;
            OP_ADD: begin
                dec.cls     = RES_ARITH;
                dec.ovf_chk = 1'b1;
            end
            OP_SUB: begin
                dec.cls     = RES_ARITH;
                dec.sub_en  = 1'b1;
                dec.ovf_chk = 1'b1;
            end
            OP_SUBU, OP_SLT: begin
                dec.cls    = RES_ARITH;
                dec.sub_en = 1'b1;
            end
            OP_MUL: begin
                dec.cls        = RES_MUL;
                dec.mul_signed = 1'b1;
            end
            OP_MULT: begin
                dec.cls        = RES_HILO_ONLY;
                dec.mul_signed = 1'b1;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// ==== verilog/alu_execute.sv ====
// ALU execute stage
// Logic, shift, add/sub/compare, leading-count and multiply units
// Move result and new HI/LO pair for the register moves
module alu_execute (
    input  alu_pkg::word_t hi_i,
    input  alu_pkg::word_t lo_i,
    dec_if.exe             dec,
    unit_if.exe            units
);
    import alu_pkg::*;

    word_t  b_eff;
    word_t  sum;
    dword_t mul_a;
    dword_t mul_b;
    dword_t product;
    logic   [SHAMT_W-1:0] shamt;

    // Number of leading zeros of v
    function automatic word_t lead_zeros(word_t v);
        word_t cnt;
        logic  stop;
        cnt  = '0;
        stop = 1'b0;
        for (int i = WORD_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                stop = 1'b1;
            end else if (!stop) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    always_comb begin
        case (dec.op)
            OP_OR:   units.logic_res = dec.a | dec.b;
            OP_AND:  units.logic_res = dec.a & dec.b;
            OP_NOR:  units.logic_res = ~(dec.a | dec.b);
            OP_XOR:  units.logic_res = dec.a ^ dec.b;
            default: units.logic_res = '0;
        endcase
    end

    // Shift amount from A, value from B
    assign shamt = dec.a[SHAMT_W-1:0];

    always_comb begin
        case (dec.op)
            OP_SLL:  units.shift_res = dec.b << shamt;
            OP_SRL:  units.shift_res = dec.b >> shamt;
            OP_SRA:  units.shift_res = word_t'($signed(dec.b) >>> shamt);
            default: units.shift_res = '0;
        endcase
    end

    // Subtract as A + ~B + 1
    assign b_eff     = dec.b ^ {WORD_W{dec.sub_en}};
    assign sum       = dec.a + b_eff + word_t'(dec.sub_en);
    assign units.ovf = (dec.a[WORD_W-1] == b_eff[WORD_W-1]) &&
                       (sum[WORD_W-1] != dec.a[WORD_W-1]);

    always_comb begin
        case (dec.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: units.arith_res = sum;
            OP_SLT:  units.arith_res = word_t'($signed(dec.a) < $signed(dec.b));
            OP_SLTU: units.arith_res = word_t'(dec.a < dec.b);
            OP_CLZ:  units.arith_res = lead_zeros(dec.a);
            OP_CLO:  units.arith_res = lead_zeros(~dec.a);
            default: units.arith_res = '0;
        endcase
    end

    // Sign extension to 64 bits makes the low half the signed product
    assign mul_a   = dec.mul_signed ? {{WORD_W{dec.a[WORD_W-1]}}, dec.a} : {{WORD_W{1'b0}}, dec.a};
    assign mul_b   = dec.mul_signed ? {{WORD_W{dec.b[WORD_W-1]}}, dec.b} : {{WORD_W{1'b0}}, dec.b};
    assign product = mul_a * mul_b;

    always_comb begin
        case (dec.op)
            OP_MTHI: units.prod = {dec.a, lo_i};
            OP_MTLO: units.prod = {hi_i, dec.a};
            default: units.prod = product;
        endcase
    end

    assign units.move_res = (dec.op == OP_MFHI) ? hi_i :
                            (dec.op == OP_MFLO) ? lo_i : '0;

endmodule

// ==== verilog/alu_ifs.sv ====
// Interfaces inside the ALU
// dec_if carries the decoded command to execute and result
// unit_if carries the unit outputs from execute to result
interface dec_if;
    import alu_pkg::*;

    logic       valid;
    alu_op_e    op;
    res_class_e cls;
    word_t      a;
    word_t      b;
    logic       sub_en;
    logic       mul_signed;
    logic       ovf_chk;
    logic       illegal;

    modport dec (output valid, op, cls, a, b, sub_en, mul_signed, ovf_chk, illegal);
    modport exe (input op, a, b, sub_en, mul_signed);
    modport res (input valid, cls, ovf_chk, illegal);
endinterface

interface unit_if;
    import alu_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  move_res;
    word_t  arith_res;
    logic   ovf;
    dword_t prod;   // also carries the new HI/LO pair for MTHI and MTLO

    modport exe (output logic_res, shift_res, move_res, arith_res, ovf, prod);
    modport res (input logic_res, shift_res, move_res, arith_res, ovf, prod);
endinterface

// ==== verilog/alu_pkg.sv ====
// ALU package
// Word and double-word types, operation codes and result classes
// Width constants for the data path and the shift amount
package alu_pkg;

    localparam int WORD_W  = 32;
    localparam int SHAMT_W = 5;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] dword_t;

    // Codes 22 to 31 are not assigned and are treated as illegal
    typedef enum logic [4:0] {
        OP_OR    = 5'd0,
        OP_AND   = 5'd1,
        OP_NOR   = 5'd2,
        OP_XOR   = 5'd3,
        OP_SLL   = 5'd4,
        OP_SRL   = 5'd5,
        OP_SRA   = 5'd6,
        OP_ADD   = 5'd7,
        OP_ADDU  = 5'd8,
        OP_SUB   = 5'd9,
        OP_SUBU  = 5'd10,
        OP_SLT   = 5'd11,
        OP_SLTU  = 5'd12,
        OP_CLZ   = 5'd13,
        OP_CLO   = 5'd14,
        OP_MUL   = 5'd15,
        OP_MULT  = 5'd16,
        OP_MULTU = 5'd17,
        OP_MFHI  = 5'd18,
        OP_MFLO  = 5'd19,
        OP_MTHI  = 5'd20,
        OP_MTLO  = 5'd21
    } alu_op_e;

    // Selects which unit output lands in RESULT
    typedef enum logic [2:0] {
        RES_LOGIC     = 3'd0,
        RES_SHIFT     = 3'd1,
        RES_MOVE      = 3'd2,
        RES_ARITH     = 3'd3,
        RES_MUL       = 3'd4,
        RES_HILO_ONLY = 3'd5
    } res_class_e;

endpackage

// ==== verilog/alu_result.sv ====
// ALU write-back stage
// Result select with overflow and illegal-code suppression
// HI/LO registers, status flags and done pulse
module alu_result (
    input  logic           clk_i,
    input  logic           rst_n_i,
    dec_if.res             dec,
    unit_if.res            units,
    output logic           done_o,
    output alu_pkg::word_t result_o,
    output alu_pkg::word_t hi_o,
    output alu_pkg::word_t lo_o,
    output logic           ovf_o,
    output logic           illegal_o
);
    import alu_pkg::*;

    word_t result_q;
    word_t hi_q;
    word_t lo_q;
    logic  ovf_q;
    logic  illegal_q;
    word_t sel_res;

    always_comb begin
        case (dec.cls)
            RES_LOGIC: sel_res = units.logic_res;
            RES_SHIFT: sel_res = units.shift_res;
            RES_MOVE:  sel_res = units.move_res;
            RES_ARITH: sel_res = units.arith_res;
            RES_MUL:   sel_res = units.prod[WORD_W-1:0];
            default:   sel_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_q  <= '0;
            hi_q      <= '0;
            lo_q      <= '0;
            ovf_q     <= 1'b0;
            illegal_q <= 1'b0;
        end else if (dec.valid) begin
            // Flags describe the latest operation only
            ovf_q     <= dec.ovf_chk & units.ovf;
            illegal_q <= dec.illegal;
            if (!dec.illegal && !(dec.ovf_chk && units.ovf)) begin
                if (dec.cls == RES_HILO_ONLY) begin
                    {hi_q, lo_q} <= units.prod;
                end else begin
                    result_q <= sel_res;
                end
            end
        end
    end

    // Write-back happens at the end of the valid cycle
    assign done_o    = dec.valid;
    assign result_o  = result_q;
    assign hi_o      = hi_q;
    assign lo_o      = lo_q;
    assign ovf_o     = ovf_q;
    assign illegal_o = illegal_q;

endmodule

// ==== verilog/apb_pkg.sv ====
// APB package
// Address width and type, register offsets and status bit positions
package apb_pkg;

    localparam int APB_ADDR_W = 8;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    localparam apb_addr_t ADDR_OPA    = 8'h00;
    localparam apb_addr_t ADDR_OPB    = 8'h04;
    localparam apb_addr_t ADDR_CMD    = 8'h08;
    localparam apb_addr_t ADDR_RESULT = 8'h0C;
    localparam apb_addr_t ADDR_HI     = 8'h10;
    localparam apb_addr_t ADDR_LO     = 8'h14;
    localparam apb_addr_t ADDR_STATUS = 8'h18;

    localparam int STAT_BUSY    = 0;
    localparam int STAT_OVF     = 1;
    localparam int STAT_ILLEGAL = 2;

endpackage

// ==== verilog/apb_regs.sv ====
// APB slave for the ALU
// Operand and command registers, launch pulse and busy flag
// Read mux, read wait states and error response
module apb_regs (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  apb_pkg::apb_addr_t paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  alu_pkg::word_t     pwdata_i,
    output alu_pkg::word_t     prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               launch_o,
    output alu_pkg::alu_op_e   op_o,
    output alu_pkg::word_t     opa_o,
    output alu_pkg::word_t     opb_o,
    input  logic               done_i,
    input  alu_pkg::word_t     result_i,
    input  alu_pkg::word_t     hi_i,
    input  alu_pkg::word_t     lo_i,
    input  logic               ovf_i,
    input  logic               illegal_i
);
    import alu_pkg::*;
    import apb_pkg::*;

    word_t   opa_q;
    word_t   opb_q;
    alu_op_e cmd_q;
    logic    busy_q;
    logic    access;
    logic    mapped;
    logic    writable;
    logic    result_reg;
    logic    wr_ok;
    word_t   status;

    assign access = psel_i & penable_i;

    // Address decode
    always_comb begin
        mapped     = 1'b1;
        writable   = 1'b0;
        result_reg = 1'b0;
        case (paddr_i)
            ADDR_OPA, ADDR_OPB, ADDR_CMD: writable = 1'b1;
            ADDR_RESULT, ADDR_HI, ADDR_LO, ADDR_STATUS: result_reg = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    // Reads of results stall until the operation in flight is written back
    assign pready_o  = ~(access & ~pwrite_i & result_reg & busy_q);
    assign pslverr_o = access & pready_o & (~mapped | (pwrite_i & ~writable));

    assign wr_ok    = access & pwrite_i & writable;
    assign launch_o = wr_ok & (paddr_i == ADDR_CMD);
    assign op_o     = alu_op_e'(pwdata_i[4:0]);
    assign opa_o    = opa_q;
    assign opb_o    = opb_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            opa_q  <= '0;
            opb_q  <= '0;
            cmd_q  <= alu_op_e'(0);
            busy_q <= 1'b0;
        end else begin
            if (wr_ok && paddr_i == ADDR_OPA) begin
                opa_q <= pwdata_i;
            end
            if (wr_ok && paddr_i == ADDR_OPB) begin
                opb_q <= pwdata_i;
            end
            if (launch_o) begin
                cmd_q <= op_o;
            end
            // A new launch wins over the write-back of the previous one
            if (launch_o) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Read mux
    always_comb begin
        status               = '0;
        status[STAT_BUSY]    = busy_q;
        status[STAT_OVF]     = ovf_i;
        status[STAT_ILLEGAL] = illegal_i;
        case (paddr_i)
            ADDR_OPA:    prdata_o = opa_q;
            ADDR_OPB:    prdata_o = opb_q;
            ADDR_CMD:    prdata_o = word_t'(cmd_q);
            ADDR_RESULT: prdata_o = result_i;
            ADDR_HI:     prdata_o = hi_i;
            ADDR_LO:     prdata_o = lo_i;
            ADDR_STATUS: prdata_o = status;
            default:     prdata_o = '0;
        endcase
    end

endmodule
